/* src/mcu_config.svh */
`ifndef MCU_CONFIG_SVH
`define MCU_CONFIG_SVH

`define MCU_DATA_W         32
`define MCU_PERIPH_BASE    24'hFFFFFF  // Upper address bits of the register page

// Mailbox scratch registers
`define MCU_OFS_MBOX0      8'h00
`define MCU_OFS_MBOX1      8'h04
`define MCU_OFS_MBOX2      8'h08
`define MCU_OFS_MBOX3      8'h0C
`define MCU_OFS_MBOX4      8'h10
`define MCU_OFS_MBOX5      8'h14
`define MCU_OFS_MBOX6      8'h18
`define MCU_OFS_MBOX7      8'h1C

// Controller key words, read only
`define MCU_OFS_CONT1      8'h20
`define MCU_OFS_CONT2      8'h24
`define MCU_OFS_CONT3      8'h28
`define MCU_OFS_CONT4      8'h2C

// Target dataslot block
`define MCU_OFS_DS_ID      8'h80
`define MCU_OFS_DS_BRIDGE  8'h84
`define MCU_OFS_DS_LEN     8'h88
`define MCU_OFS_DS_OFFSET  8'h8C
`define MCU_OFS_DS_CTRL    8'h90  // Write is command, read is status
`define MCU_DS_ERR_W       3

// Millisecond timer
`define MCU_OFS_TICKS      8'h98
`define MCU_OFS_MS_COUNT   8'hC4
`define MCU_OFS_MS_COMPARE 8'hC8
`define MCU_TICKS_RESET    32'd74249  // 74.25 MHz clk_sys, minus one

`endif

/* src/mcu_pkg.sv */
package mcu_pkg;

	// Bus operation carried down the pipe
	typedef enum logic [1:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE
	} bus_op_e;

	// One selector per mapped register, mailbox and key words kept contiguous
	typedef enum logic [4:0] {
		SEL_UNMAPPED,  // Off page or unknown offset
		SEL_MBOX0,
		SEL_MBOX1,
		SEL_MBOX2,
		SEL_MBOX3,
		SEL_MBOX4,
		SEL_MBOX5,
		SEL_MBOX6,
		SEL_MBOX7,
		SEL_CONT1,
		SEL_CONT2,
		SEL_CONT3,
		SEL_CONT4,
		SEL_DS_ID,
		SEL_DS_BRIDGE,
		SEL_DS_LEN,
		SEL_DS_OFFSET,
		SEL_DS_CTRL,
		SEL_TICKS,
		SEL_MS_COUNT,
		SEL_MS_COMPARE
	} reg_sel_e;

endpackage

/* src/mcu_bus_decode.sv */
`timescale 1ns/1ps
`include "mcu_config.svh"

module mcu_bus_decode (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   cpu_valid,
	input  logic                   cpu_wr,
	input  logic [`MCU_DATA_W-1:0] cpu_addr,
	input  logic [`MCU_DATA_W-1:0] cpu_wdata,
	output mcu_pkg::bus_op_e       op,
	output mcu_pkg::reg_sel_e      sel,
	output logic [`MCU_DATA_W-1:0] wdata
);
	import mcu_pkg::*;

	reg_sel_e sel_dec;  // Selector before the register stage
	logic     in_page;

	assign in_page = (cpu_addr[`MCU_DATA_W-1:8] == `MCU_PERIPH_BASE);

	// Low byte to register, anything else falls to unmapped
	always_comb begin
		sel_dec = SEL_UNMAPPED;
		if (in_page) begin
			case (cpu_addr[7:0])
				`MCU_OFS_MBOX0:      sel_dec = SEL_MBOX0;
				`MCU_OFS_MBOX1:      sel_dec = SEL_MBOX1;
				`MCU_OFS_MBOX2:      sel_dec = SEL_MBOX2;
				`MCU_OFS_MBOX3:      sel_dec = SEL_MBOX3;
				`MCU_OFS_MBOX4:      sel_dec = SEL_MBOX4;
				`MCU_OFS_MBOX5:      sel_dec = SEL_MBOX5;
				`MCU_OFS_MBOX6:      sel_dec = SEL_MBOX6;
				`MCU_OFS_MBOX7:      sel_dec = SEL_MBOX7;
				`MCU_OFS_CONT1:      sel_dec = SEL_CONT1;
				`MCU_OFS_CONT2:      sel_dec = SEL_CONT2;
				`MCU_OFS_CONT3:      sel_dec = SEL_CONT3;
				`MCU_OFS_CONT4:      sel_dec = SEL_CONT4;
				`MCU_OFS_DS_ID:      sel_dec = SEL_DS_ID;
				`MCU_OFS_DS_BRIDGE:  sel_dec = SEL_DS_BRIDGE;
				`MCU_OFS_DS_LEN:     sel_dec = SEL_DS_LEN;
				`MCU_OFS_DS_OFFSET:  sel_dec = SEL_DS_OFFSET;
				`MCU_OFS_DS_CTRL:    sel_dec = SEL_DS_CTRL;
				`MCU_OFS_TICKS:      sel_dec = SEL_TICKS;
				`MCU_OFS_MS_COUNT:   sel_dec = SEL_MS_COUNT;
				`MCU_OFS_MS_COMPARE: sel_dec = SEL_MS_COMPARE;
				default:             sel_dec = SEL_UNMAPPED;  // Hole in the map
			endcase
		end
	end

	// Command stage, no back-pressure so every valid is taken
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			op    <= OP_NONE;
			sel   <= SEL_UNMAPPED;
			wdata <= '0;
		end else begin
			op <= OP_NONE;  // Bubble by default
			if (cpu_valid) begin
				op    <= cpu_wr ? OP_WRITE : OP_READ;  // Unmapped keeps its op too
				sel   <= sel_dec;
				wdata <= cpu_wdata;
			end
		end
	end

	// No phantom command may enter the pipe
	a_idle_no_op: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!cpu_valid |=> op == OP_NONE);

endmodule

/* src/mcu_reg_exec.sv */
`timescale 1ns/1ps
`include "mcu_config.svh"

module mcu_reg_exec (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  mcu_pkg::bus_op_e         op,
	input  mcu_pkg::reg_sel_e        sel,
	input  logic [`MCU_DATA_W-1:0]   wdata,
	input  logic                     ds_done,
	output logic [8*`MCU_DATA_W-1:0] mbox_flat,
	output logic [15:0]              ds_id,
	output logic [`MCU_DATA_W-1:0]   ds_bridge,
	output logic [`MCU_DATA_W-1:0]   ds_length,
	output logic [`MCU_DATA_W-1:0]   ds_offset,
	output logic                     ds_read,
	output logic                     ds_write,
	output logic                     ds_irq,
	output logic [`MCU_DATA_W-1:0]   ticks_per_ms,
	output logic                     ms_reset,
	output logic                     irq_arm,
	output logic                     compare_wr
);
	import mcu_pkg::*;

	logic [7:0][`MCU_DATA_W-1:0] mbox;  // Scratch words, index 0 at bits 31:0
	logic [2:0]                  mbox_idx;
	logic                        wr_en;
	logic                        ds_irq_en;  // Bit 2 of the control write
	logic                        ds_done_q;  // Delayed copy for edge detect

	assign wr_en     = (op == OP_WRITE);
	assign mbox_idx  = 3'(sel - SEL_MBOX0);  // Contiguous selector range
	assign mbox_flat = mbox;

	// Timer strobes, one cycle since op is a single-cycle slot
	assign ms_reset   = wr_en && (sel == SEL_MS_COUNT);
	assign compare_wr = wr_en && (sel == SEL_MS_COMPARE);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			mbox         <= '0;
			ds_id        <= '0;
			ds_bridge    <= '0;
			ds_length    <= '0;
			ds_offset    <= '0;
			ds_read      <= 1'b0;
			ds_write     <= 1'b0;
			ds_irq       <= 1'b0;
			ds_irq_en    <= 1'b0;
			ds_done_q    <= 1'b0;
			ticks_per_ms <= `MCU_TICKS_RESET;
			irq_arm      <= 1'b0;
		end else begin
			ds_read   <= 1'b0;  // Command pulses self clear
			ds_write  <= 1'b0;
			ds_done_q <= ds_done;
			ds_irq    <= ds_done && !ds_done_q && ds_irq_en;  // Rising edge of done only

			if (wr_en) begin
				case (sel)
					SEL_MBOX0, SEL_MBOX1, SEL_MBOX2, SEL_MBOX3,
					SEL_MBOX4, SEL_MBOX5, SEL_MBOX6, SEL_MBOX7:
						mbox[mbox_idx] <= wdata;
					SEL_DS_ID:     ds_id     <= wdata[15:0];  // Upper bits dropped
					SEL_DS_BRIDGE: ds_bridge <= wdata;
					SEL_DS_LEN:    ds_length <= wdata;
					SEL_DS_OFFSET: ds_offset <= wdata;
					SEL_DS_CTRL: begin
						ds_read   <= wdata[0];
						ds_write  <= wdata[1];
						ds_irq_en <= wdata[2];
					end
					SEL_TICKS:      ticks_per_ms <= wdata;
					SEL_MS_COUNT:   irq_arm      <= 1'b0;  // Counter reset also disarms
					SEL_MS_COMPARE: irq_arm      <= 1'b1;
					default: ;  // Read-only or unmapped, write ignored
				endcase
			end
		end
	end

	// Target side is edge triggered, a command is never a level
	a_ds_read_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ds_read |=> !ds_read);
	a_ds_write_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ds_write |=> !ds_write);

endmodule

/* src/mcu_ms_timer.sv */
`timescale 1ns/1ps
`include "mcu_config.svh"

module mcu_ms_timer (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic [`MCU_DATA_W-1:0] ticks_per_ms,
	input  logic                   ms_reset,
	input  logic                   irq_arm,
	input  logic                   compare_wr,
	input  logic [`MCU_DATA_W-1:0] compare_val,
	output logic [`MCU_DATA_W-1:0] ms_count,
	output logic [`MCU_DATA_W-1:0] ms_compare,
	output logic                   timer_irq
);

	logic [`MCU_DATA_W-1:0] tick;     // clk_sys cycles inside the current ms
	logic [`MCU_DATA_W-1:0] ms_next;
	logic                   ms_wrap;

	assign ms_next = ms_count + 1'b1;
	assign ms_wrap = (tick >= ticks_per_ms);  // Also recovers if ticks shrinks mid count

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick       <= '0;
			ms_count   <= '0;
			ms_compare <= '0;
			timer_irq  <= 1'b0;
		end else begin
			if (compare_wr)
				ms_compare <= compare_val;
			if (ms_reset) begin
				tick      <= '0;  // Synchronous counter clear
				ms_count  <= '0;
				timer_irq <= 1'b0;
			end else if (ms_wrap) begin
				tick     <= '0;
				ms_count <= ms_next;
				// Fires as the count lands on a nonzero compare
				if (irq_arm && (ms_compare != '0) && (ms_next == ms_compare))
					timer_irq <= 1'b1;
			end else begin
				tick <= tick + 1'b1;
			end
		end
	end

	// Interrupt only ever raised from an armed compare
	a_irq_needs_arm: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(timer_irq) |-> $past(irq_arm));

endmodule

/* src/mcu_result.sv */
`timescale 1ns/1ps
`include "mcu_config.svh"

module mcu_result (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  mcu_pkg::bus_op_e         op,
	input  mcu_pkg::reg_sel_e        sel,
	input  logic [8*`MCU_DATA_W-1:0] mbox_flat,
	input  logic [4*`MCU_DATA_W-1:0] cont_key_flat,
	input  logic [15:0]              ds_id,
	input  logic [`MCU_DATA_W-1:0]   ds_bridge,
	input  logic [`MCU_DATA_W-1:0]   ds_length,
	input  logic [`MCU_DATA_W-1:0]   ds_offset,
	input  logic                     ds_ack,
	input  logic                     ds_done,
	input  logic [`MCU_DS_ERR_W-1:0] ds_err,
	input  logic [`MCU_DATA_W-1:0]   ticks_per_ms,
	input  logic [`MCU_DATA_W-1:0]   ms_count,
	input  logic [`MCU_DATA_W-1:0]   ms_compare,
	output logic                     rsp_ready,
	output logic [`MCU_DATA_W-1:0]   rsp_data
);
	import mcu_pkg::*;

	logic [7:0][`MCU_DATA_W-1:0] mbox;
	logic [3:0][`MCU_DATA_W-1:0] cont_key;  // cont1 in the lowest word
	logic [2:0]                  mbox_idx;
	logic [1:0]                  key_idx;
	logic [`MCU_DATA_W-1:0]      rd_mux;

	assign mbox     = mbox_flat;
	assign cont_key = cont_key_flat;
	assign mbox_idx = 3'(sel - SEL_MBOX0);
	assign key_idx  = 2'(sel - SEL_CONT1);

	always_comb begin
		case (sel)
			SEL_MBOX0, SEL_MBOX1, SEL_MBOX2, SEL_MBOX3,
			SEL_MBOX4, SEL_MBOX5, SEL_MBOX6, SEL_MBOX7:
				rd_mux = mbox[mbox_idx];
			SEL_CONT1, SEL_CONT2, SEL_CONT3, SEL_CONT4:
				rd_mux = cont_key[key_idx];
			SEL_DS_ID:      rd_mux = {{(`MCU_DATA_W-16){1'b0}}, ds_id};
			SEL_DS_BRIDGE:  rd_mux = ds_bridge;
			SEL_DS_LEN:     rd_mux = ds_length;
			SEL_DS_OFFSET:  rd_mux = ds_offset;
			// Status, ack at 4, done at 3, error code below
			SEL_DS_CTRL:    rd_mux = {{(`MCU_DATA_W-`MCU_DS_ERR_W-2){1'b0}}, ds_ack, ds_done, ds_err};
			SEL_TICKS:      rd_mux = ticks_per_ms;
			SEL_MS_COUNT:   rd_mux = ms_count;
			SEL_MS_COMPARE: rd_mux = ms_compare;
			default:        rd_mux = '0;  // Unmapped reads as zero
		endcase
	end

	// Response stage, one strobe per command
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rsp_ready <= 1'b0;
			rsp_data  <= '0;
		end else begin
			rsp_ready <= (op != OP_NONE);
			rsp_data  <= (op == OP_READ) ? rd_mux : '0;  // Writes answer zero
		end
	end

	a_data_quiet: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!rsp_ready |-> rsp_data == '0);

endmodule

/* src/mcu_periph_top.sv */
`timescale 1ns/1ps
`include "mcu_config.svh"

module mcu_periph_top (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     cpu_valid,
	input  logic                     cpu_wr,
	input  logic [`MCU_DATA_W-1:0]   cpu_addr,
	input  logic [`MCU_DATA_W-1:0]   cpu_wdata,
	output logic                     rsp_ready,
	output logic [`MCU_DATA_W-1:0]   rsp_data,
	input  logic [`MCU_DATA_W-1:0]   cont1_key,
	input  logic [`MCU_DATA_W-1:0]   cont2_key,
	input  logic [`MCU_DATA_W-1:0]   cont3_key,
	input  logic [`MCU_DATA_W-1:0]   cont4_key,
	input  logic                     ds_ack,
	input  logic                     ds_done,
	input  logic [`MCU_DS_ERR_W-1:0] ds_err,
	output logic [15:0]              ds_id,
	output logic [`MCU_DATA_W-1:0]   ds_bridge,
	output logic [`MCU_DATA_W-1:0]   ds_length,
	output logic [`MCU_DATA_W-1:0]   ds_offset,
	output logic                     ds_read,
	output logic                     ds_write,
	output logic                     ds_irq,
	output logic                     timer_irq
);
	import mcu_pkg::*;

	bus_op_e                  op;     // Decoded command slot
	reg_sel_e                 sel;
	logic [`MCU_DATA_W-1:0]   wdata;
	logic [8*`MCU_DATA_W-1:0] mbox_flat;
	logic [`MCU_DATA_W-1:0]   ticks_per_ms;
	logic                     ms_reset;
	logic                     irq_arm;
	logic                     compare_wr;
	logic [`MCU_DATA_W-1:0]   ms_count;
	logic [`MCU_DATA_W-1:0]   ms_compare;

	mcu_bus_decode u_decode (
		.clk_sys, .reset_n, .cpu_valid, .cpu_wr, .cpu_addr, .cpu_wdata,
		.op, .sel, .wdata
	);

	mcu_reg_exec u_exec (
		.clk_sys, .reset_n, .op, .sel, .wdata, .ds_done,
		.mbox_flat, .ds_id, .ds_bridge, .ds_length, .ds_offset,
		.ds_read, .ds_write, .ds_irq,
		.ticks_per_ms, .ms_reset, .irq_arm, .compare_wr
	);

	// Compare value comes straight off the decoded write data
	mcu_ms_timer u_timer (
		.clk_sys, .reset_n, .ticks_per_ms, .ms_reset, .irq_arm, .compare_wr,
		.compare_val (wdata),
		.ms_count, .ms_compare, .timer_irq
	);

	mcu_result u_result (
		.clk_sys, .reset_n, .op, .sel, .mbox_flat,
		.cont_key_flat ({cont4_key, cont3_key, cont2_key, cont1_key}),
		.ds_id, .ds_bridge, .ds_length, .ds_offset, .ds_ack, .ds_done, .ds_err,
		.ticks_per_ms, .ms_count, .ms_compare,
		.rsp_ready, .rsp_data
	);

endmodule

/* tb/tb_mcu_periph.sv */
`timescale 1ns/1ps
`include "mcu_config.svh"

module tb_mcu_periph;
	localparam int MODE_EQ     = 0;  // Exact match
	localparam int MODE_GE     = 1;  // At least the table value
	localparam int MODE_LT     = 2;  // Below the table value
	localparam int TBL_MAX     = 64;
	localparam int DRAIN_LIMIT = 100;
	localparam int IRQ_LIMIT   = 200;

	logic        clk_sys = 1'b0;
	logic        reset_n;
	logic        cpu_valid;
	logic        cpu_wr;
	logic [31:0] cpu_addr;
	logic [31:0] cpu_wdata;
	logic        rsp_ready;
	logic [31:0] rsp_data;
	logic [31:0] cont1_key, cont2_key, cont3_key, cont4_key;
	logic        ds_ack;
	logic        ds_done;
	logic [2:0]  ds_err;
	logic [15:0] ds_id;
	logic [31:0] ds_bridge, ds_length, ds_offset;
	logic        ds_read, ds_write, ds_irq, timer_irq;

	// One bus command per row
	logic        tbl_wr    [TBL_MAX];
	logic [31:0] tbl_addr  [TBL_MAX];
	logic [31:0] tbl_wdata [TBL_MAX];
	logic [31:0] tbl_exp   [TBL_MAX];
	int          tbl_mode  [TBL_MAX];
	int          tbl_n     = 0;
	int          tbl_next  = 0;  // First row not yet applied

	int     pend_row [$];  // Rows waiting for rsp_ready
	int     pend_due [$];  // Negedge count where the answer is due
	int     ncyc       = 0;
	int     err_cnt    = 0;
	int     n_ds_read  = 0;
	int     n_ds_write = 0;
	int     n_ds_irq   = 0;
	int     mon_row;
	integer seed       = 32'h9e63_9b34;
	logic [31:0] mbox_val [8];

	mcu_periph_top DUT (.*);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] page_addr(input int ofs);
		return {`MCU_PERIPH_BASE, ofs[7:0]};
	endfunction

	task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
		input logic [31:0] exp, input int mode);
		tbl_wr[tbl_n]    = wr;
		tbl_addr[tbl_n]  = addr;
		tbl_wdata[tbl_n] = wdata;
		tbl_exp[tbl_n]   = exp;
		tbl_mode[tbl_n]  = mode;
		tbl_n++;
	endtask

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		err_cnt++;
		$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
	endtask

	task automatic finish_run();
		$display("Errors: %0d", err_cnt);
		if (err_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic check_rsp(input int r);
		if (tbl_mode[r] == MODE_GE) begin
			assert (rsp_data >= tbl_exp[r]) else report_value("rsp_data (min)", tbl_exp[r], rsp_data);
		end else if (tbl_mode[r] == MODE_LT) begin
			assert (rsp_data < tbl_exp[r]) else report_value("rsp_data (below)", tbl_exp[r], rsp_data);
		end else begin
			assert (rsp_data === tbl_exp[r]) else report_value("rsp_data", tbl_exp[r], rsp_data);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pend_row.size() != 0 && n < DRAIN_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (pend_row.size() != 0) begin
			$display("Timeout: %0d bus responses never arrived", pend_row.size());
			err_cnt++;
			finish_run();
		end
	endtask

	// Rows go out back to back on consecutive cycles
	task automatic run_rows();
		while (tbl_next < tbl_n) begin
			@(posedge clk_sys);
			cpu_valid <= 1'b1;
			cpu_wr    <= tbl_wr[tbl_next];
			cpu_addr  <= tbl_addr[tbl_next];
			cpu_wdata <= tbl_wdata[tbl_next];
			pend_row.push_back(tbl_next);
			pend_due.push_back(ncyc + 3);  // Answer due three falling edges on
			tbl_next++;
		end
		@(posedge clk_sys);
		cpu_valid <= 1'b0;
		cpu_wr    <= 1'b0;
		wait_drain();
	endtask

	task automatic wait_ds_irq(input int base);
		int n;
		n = 0;
		while (n_ds_irq == base && n < IRQ_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		repeat (4) @(negedge clk_sys);  // Settle window where a second pulse would show
	endtask

	task automatic wait_timer_irq();
		int n;
		n = 0;
		while (!timer_irq && n < IRQ_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		assert (timer_irq) else begin
			err_cnt++;
			$display("timer_irq did not rise within %0d cycles", IRQ_LIMIT);
		end
	endtask

	// Response monitor on the falling edge where outputs are settled
	always @(negedge clk_sys) begin
		ncyc++;
		if (ds_read)  n_ds_read++;
		if (ds_write) n_ds_write++;
		if (ds_irq)   n_ds_irq++;
		if (pend_due.size() != 0 && pend_due[0] == ncyc) begin
			mon_row = pend_row.pop_front();
			void'(pend_due.pop_front());
			assert (rsp_ready) else begin
				err_cnt++;
				$display("No response for row %0d at %0t", mon_row, $time);
			end
			if (rsp_ready) check_rsp(mon_row);
		end else begin
			assert (!rsp_ready) else begin
				err_cnt++;
				$display("Response without a pending command at %0t", $time);
			end
		end
	end

	initial begin
		int i;
		int base;
		reset_n   = 1'b0;
		cpu_valid = 1'b0;
		cpu_wr    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cont1_key = 32'h0001_a5c3;
		cont2_key = 32'h8002_3c5a;
		cont3_key = 32'h4003_f00f;
		cont4_key = 32'h2004_0ff0;
		ds_ack    = 1'b0;
		ds_done   = 1'b0;
		ds_err    = '0;
		repeat (8) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(posedge clk_sys);

		// Mailbox writes then reads in one burst
		for (i = 0; i < 8; i++) begin
			mbox_val[i] = $random(seed);
			add_row(1'b1, page_addr(`MCU_OFS_MBOX0 + 4 * i), mbox_val[i], '0, MODE_EQ);
		end
		for (i = 0; i < 8; i++)
			add_row(1'b0, page_addr(`MCU_OFS_MBOX0 + 4 * i), '0, mbox_val[i], MODE_EQ);
		run_rows();

		// Key words then a hole in the map and an off-page address
		add_row(1'b0, page_addr(`MCU_OFS_CONT1), '0, cont1_key, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_CONT2), '0, cont2_key, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_CONT3), '0, cont3_key, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_CONT4), '0, cont4_key, MODE_EQ);
		add_row(1'b0, page_addr(8'h40), '0, '0, MODE_EQ);
		add_row(1'b0, 32'h0000_0010, '0, '0, MODE_EQ);
		run_rows();

		// Dataslot command registers with a 16 bit id
		@(posedge clk_sys);
		ds_ack <= 1'b1;
		ds_err <= 3'b101;
		add_row(1'b1, page_addr(`MCU_OFS_DS_ID), 32'habcd_1234, '0, MODE_EQ);
		add_row(1'b1, page_addr(`MCU_OFS_DS_BRIDGE), 32'h1000_0400, '0, MODE_EQ);
		add_row(1'b1, page_addr(`MCU_OFS_DS_LEN), 32'h0002_0000, '0, MODE_EQ);
		add_row(1'b1, page_addr(`MCU_OFS_DS_OFFSET), 32'h0000_0c00, '0, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_DS_ID), '0, 32'h0000_1234, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_DS_BRIDGE), '0, 32'h1000_0400, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_DS_LEN), '0, 32'h0002_0000, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_DS_OFFSET), '0, 32'h0000_0c00, MODE_EQ);
		add_row(1'b1, page_addr(`MCU_OFS_DS_CTRL), 32'h1, '0, MODE_EQ);  // Read command
		add_row(1'b1, page_addr(`MCU_OFS_DS_CTRL), 32'h2, '0, MODE_EQ);  // Write command
		add_row(1'b0, page_addr(`MCU_OFS_DS_CTRL), '0, 32'h0000_0015, MODE_EQ);  // Ack and err 5
		run_rows();
		assert (n_ds_read == 1) else report_value("ds_read pulses", 1, n_ds_read);
		assert (n_ds_write == 1) else report_value("ds_write pulses", 1, n_ds_write);
		// Command ports seen by the target
		assert (ds_id === 16'h1234) else report_value("ds_id", 32'h0000_1234, ds_id);
		assert (ds_bridge === 32'h1000_0400) else report_value("ds_bridge", 32'h1000_0400, ds_bridge);
		assert (ds_length === 32'h0002_0000) else report_value("ds_length", 32'h0002_0000, ds_length);
		assert (ds_offset === 32'h0000_0c00) else report_value("ds_offset", 32'h0000_0c00, ds_offset);

		// Done interrupt enabled by bit 2
		add_row(1'b1, page_addr(`MCU_OFS_DS_CTRL), 32'h4, '0, MODE_EQ);
		run_rows();
		base = n_ds_irq;
		@(posedge clk_sys);
		ds_done <= 1'b1;
		wait_ds_irq(base);
		assert (n_ds_irq == base + 1) else report_value("ds_irq pulses", base + 1, n_ds_irq - base);
		add_row(1'b0, page_addr(`MCU_OFS_DS_CTRL), '0, 32'h0000_001d, MODE_EQ);  // Done now set
		run_rows();
		@(posedge clk_sys);
		ds_done <= 1'b0;
		add_row(1'b1, page_addr(`MCU_OFS_DS_CTRL), 32'h0, '0, MODE_EQ);  // Enable off
		run_rows();
		base = n_ds_irq;
		@(posedge clk_sys);
		ds_done <= 1'b1;
		wait_ds_irq(base);
		assert (n_ds_irq == base) else report_value("ds_irq pulses", 0, n_ds_irq - base);

		// Timer at 4 cycles per ms with compare at 5
		add_row(1'b1, page_addr(`MCU_OFS_TICKS), 32'd3, '0, MODE_EQ);
		add_row(1'b1, page_addr(`MCU_OFS_MS_COUNT), '0, '0, MODE_EQ);
		add_row(1'b1, page_addr(`MCU_OFS_MS_COMPARE), 32'd5, '0, MODE_EQ);
		run_rows();
		wait_timer_irq();
		add_row(1'b0, page_addr(`MCU_OFS_MS_COUNT), '0, 32'd5, MODE_GE);
		run_rows();
		add_row(1'b1, page_addr(`MCU_OFS_MS_COUNT), '0, '0, MODE_EQ);
		add_row(1'b0, page_addr(`MCU_OFS_MS_COUNT), '0, 32'd5, MODE_LT);
		run_rows();
		assert (!timer_irq) else begin
			err_cnt++;
			$display("timer_irq still high after the counter reset");
		end

		finish_run();
	end

endmodule

/* tb.f */
+incdir+src
src/mcu_pkg.sv
src/mcu_bus_decode.sv
src/mcu_reg_exec.sv
src/mcu_ms_timer.sv
src/mcu_result.sv
src/mcu_periph_top.sv
tb/tb_mcu_periph.sv
